// ==== list.f ====
common/sand_pkg.sv
design/sand_scanner.sv
design/fall_chooser.sv
design/frame_writer.sv
design/sand_engine.sv
bench/tb_sand_engine.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator and run; the exit status is the simulation result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_sand_engine -f list.f -o tb_sand_engine &&
./obj_dir/tb_sand_engine || exit 1

// ==== bench/tb_sand_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sand_engine
    import sand_pkg::*;
    ();

    localparam int COLUMNS = 8;
    localparam int ROWS = 6;
    localparam int CELLS = COLUMNS * ROWS;
    localparam int MEM_DEPTH = 64;
    localparam int NUM_TESTS = 5;
    localparam int FRAME_TIMEOUT = 2000;

    typedef logic [5:0] idx_t;

    // Rows split by '/', s sand, w water, k smoke, digits mark a set holding one grain
    // An empty initial frame is filled at random
    string test_name [NUM_TESTS] = '{"static", "one_diagonal", "free_fall", "random_a", "random_b"};
    string init_frame [NUM_TESTS] = '{
        "w......k/......../...w..../...s..../..www.../s..s...s",
        "s......s/w......w/...s..../s.ww..../ww.....s/......ww",
        "......s./...s.w../......../s....s../.....w../........",
        "",
        ""
    };
    string next_frame [NUM_TESTS] = '{
        "w......k/......../...w..../...s..../..www.../s..s...s",
        "......../ws....sw/......../s.wws.../ww.....s/......ww",
        "......../.....w33/..111.../......../22..4w4./........",
        "",
        ""
    };

    logic  clk_i;
    logic  reset_i;
    logic  ready_i;
    logic  load_req;
    cell_e vram_rd_data = CELL_EMPTY;
    cell_e ram_rd_data = CELL_EMPTY;
    addr_t vram_rd_addr;
    addr_t ram_rd_addr;
    addr_t vram_wr_addr;
    addr_t ram_wr_addr;
    cell_e vram_wr_data;
    cell_e ram_wr_data;
    logic  vram_wr_en;
    logic  ram_wr_en;
    logic  done;

    cell_e vram [MEM_DEPTH];
    cell_e ram [MEM_DEPTH];
    cell_e frame_init [MEM_DEPTH];
    cell_e model_vram [MEM_DEPTH];
    cell_e model_ram [MEM_DEPTH];
    addr_t ram_log [$];
    int    done_count = 0;
    string cur_test = "reset";

    sand_engine #(
        .COLUMNS (COLUMNS),
        .ROWS    (ROWS)
    ) u_dut (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .ready_i        (ready_i),
        .vram_rd_data_i (vram_rd_data),
        .ram_rd_data_i  (ram_rd_data),
        .vram_rd_addr_o (vram_rd_addr),
        .ram_rd_addr_o  (ram_rd_addr),
        .vram_wr_addr_o (vram_wr_addr),
        .ram_wr_addr_o  (ram_wr_addr),
        .vram_wr_data_o (vram_wr_data),
        .ram_wr_data_o  (ram_wr_data),
        .vram_wr_en_o   (vram_wr_en),
        .ram_wr_en_o    (ram_wr_en),
        .done_o         (done)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // Both frame buffers, one-cycle reads, cells past the grid read empty
    always @(posedge clk_i) begin
        if (load_req) begin
            for (int a = 0; a < MEM_DEPTH; a++) begin
                vram[idx_t'(a)] <= frame_init[idx_t'(a)];
                ram[idx_t'(a)] <= CELL_EMPTY;
            end
        end else begin
            if (vram_wr_en) begin
                vram[vram_wr_addr[5:0]] <= vram_wr_data;
            end
            if (ram_wr_en) begin
                ram[ram_wr_addr[5:0]] <= ram_wr_data;
                ram_log.push_back(ram_wr_addr);
            end
        end
        vram_rd_data <= vram[vram_rd_addr[5:0]];
        ram_rd_data <= ram[ram_rd_addr[5:0]];
    end

    always @(negedge clk_i) begin
        if (done) begin
            done_count <= done_count + 1;
        end
    end

    task automatic check(string what, int expected, int actual);
        if (expected != actual) begin
            $display("mismatch in %s: %s expected %0d actual %0d",
                     cur_test, what, expected, actual);
            $display("Errors found");
            $fatal(1, "stopped at the first error");
        end
    endtask

    function automatic cell_e decode_cell(byte ch);
        case (ch)
            "s": return CELL_SAND;
            "w": return CELL_WATER;
            "k": return CELL_SMOKE;
            default: return CELL_EMPTY;
        endcase
    endfunction

    function automatic bit taken(int a);
        return model_vram[idx_t'(a)] != CELL_EMPTY || model_ram[idx_t'(a)] != CELL_EMPTY;
    endfunction

    // Mask bits: stay, down, down-left, down-right
    function automatic logic [3:0] allowed_moves(int a);
        int   col;
        logic occ_down;
        logic occ_left;
        logic occ_right;
        col = a % COLUMNS;
        if (model_vram[idx_t'(a)] != CELL_SAND || a >= CELLS - COLUMNS) begin
            return 4'b0001;
        end
        occ_down = taken(a + COLUMNS);
        occ_left = (col == 0) || taken(a + COLUMNS - 1);
        occ_right = (col == COLUMNS - 1) || taken(a + COLUMNS + 1);
        if (!occ_down) begin
            return {!occ_right, !occ_left, 2'b10};
        end
        if (occ_left && occ_right) begin
            return 4'b0001;
        end
        return {!occ_right, !occ_left, 2'b00};
    endfunction

    task automatic build_frame(string pattern);
        int r;
        for (int a = 0; a < MEM_DEPTH; a++) begin
            frame_init[idx_t'(a)] = CELL_EMPTY;
            if (a < CELLS && pattern.len() > 0) begin
                frame_init[idx_t'(a)] = decode_cell(pattern[a + a / COLUMNS]);
            end else if (a < CELLS) begin
                r = $urandom % 8;
                if (r < 3) begin
                    frame_init[idx_t'(a)] = CELL_SAND;
                end else if (r == 3) begin
                    frame_init[idx_t'(a)] = CELL_WATER;
                end else if (r == 4) begin
                    frame_init[idx_t'(a)] = CELL_SMOKE;
                end
            end
        end
    endtask

    task automatic run_frame();
        int cycles;
        @(posedge clk_i);
        load_req <= 1'b1;
        @(posedge clk_i);
        load_req <= 1'b0;
        ready_i <= 1'b1;
        @(posedge clk_i);
        ready_i <= 1'b0;
        cycles = 0;
        @(negedge clk_i);
        while (!done) begin
            if (cycles == FRAME_TIMEOUT) begin
                $display("timeout: test %s saw no done_o pulse within %0d cycles",
                         cur_test, FRAME_TIMEOUT);
                $display("Errors found");
                $fatal(1, "frame did not finish");
            end
            cycles++;
            @(negedge clk_i);
        end
        @(negedge clk_i);
        check("done_o low after its pulse", 0, done);
    endtask

    // Walks the frame in scan order and follows each grain through the ram writes
    task automatic replay_frame();
        logic [3:0] allowed;
        int         target;
        int         grains;
        int         sand_in;
        int         sand_out;
        bit         hit;
        grains = 0;
        sand_in = 0;
        sand_out = 0;
        for (int a = 0; a < MEM_DEPTH; a++) begin
            model_vram[idx_t'(a)] = frame_init[idx_t'(a)];
            model_ram[idx_t'(a)] = CELL_EMPTY;
            grains += (frame_init[idx_t'(a)] != CELL_EMPTY) ? 1 : 0;
        end
        check("number of ram writes", grains, ram_log.size());
        for (int a = 0; a < CELLS; a++) begin
            if (frame_init[idx_t'(a)] != CELL_EMPTY) begin
                allowed = allowed_moves(a);
                target = int'(ram_log.pop_front());
                hit = (target == a && allowed[0])
                    || (target == a + COLUMNS && allowed[1])
                    || (target == a + COLUMNS - 1 && allowed[2])
                    || (target == a + COLUMNS + 1 && allowed[3]);
                check($sformatf("cell %0d written to %0d, allowed set %b", a, target, allowed),
                      1, int'(hit));
                if (target != a) begin
                    model_vram[idx_t'(a)] = CELL_EMPTY;
                end
                model_ram[idx_t'(target)] = frame_init[idx_t'(a)];
            end
        end
        for (int a = 0; a < CELLS; a++) begin
            check($sformatf("ram[%0d]", a), int'(model_ram[idx_t'(a)]), int'(ram[idx_t'(a)]));
            check($sformatf("vram[%0d]", a), int'(model_vram[idx_t'(a)]), int'(vram[idx_t'(a)]));
            sand_in += (frame_init[idx_t'(a)] == CELL_SAND) ? 1 : 0;
            sand_out += (ram[idx_t'(a)] == CELL_SAND) ? 1 : 0;
        end
        check("sand cells in ram", sand_in, sand_out);
    endtask

    task automatic compare_expected(string pattern);
        int  set_sand [10];
        int  set_id;
        byte ch;
        foreach (set_sand[s]) begin
            set_sand[s] = -1;
        end
        for (int a = 0; a < CELLS; a++) begin
            ch = pattern[a + a / COLUMNS];
            if (ch >= "1" && ch <= "9") begin
                set_id = ch - "0";
                set_sand[set_id] = (set_sand[set_id] < 0) ? 0 : set_sand[set_id];
                set_sand[set_id] += (ram[idx_t'(a)] == CELL_SAND) ? 1 : 0;
            end else begin
                check($sformatf("ram[%0d] against the table", a),
                      int'(decode_cell(ch)), int'(ram[idx_t'(a)]));
            end
        end
        foreach (set_sand[s]) begin
            if (set_sand[s] >= 0) begin
                check($sformatf("grains in allowed set %0d", s), 1, set_sand[s]);
            end
        end
    endtask

    initial begin
        int seed_value;
        seed_value = $urandom(32'he50f11d6);
        reset_i = 1'b1;
        ready_i = 1'b0;
        load_req = 1'b1;
        for (int a = 0; a < MEM_DEPTH; a++) begin
            frame_init[idx_t'(a)] = CELL_EMPTY;
        end
        repeat (16) @(posedge clk_i);
        reset_i <= 1'b0;
        load_req <= 1'b0;

        cur_test = "idle";
        repeat (20) begin
            @(negedge clk_i);
            check("done_o while idle", 0, done);
            check("vram_wr_en_o while idle", 0, vram_wr_en);
            check("ram_wr_en_o while idle", 0, ram_wr_en);
        end

        for (int t = 0; t < NUM_TESTS; t++) begin
            cur_test = test_name[t];
            build_frame(init_frame[t]);
            ram_log.delete();
            run_frame();
            check("done_o pulses so far", t + 1, done_count);
            replay_frame();
            if (next_frame[t].len() > 0) begin
                compare_expected(next_frame[t]);
            end
        end

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/sand_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module sand_engine
    import sand_pkg::*;
    #(
        parameter int COLUMNS = 640,
        parameter int ROWS = 480
    )(
        input  wire         clk_i,
        input  wire         reset_i,
        input  wire         ready_i,
        input  wire cell_e  vram_rd_data_i,
        input  wire cell_e  ram_rd_data_i,
        output addr_t       vram_rd_addr_o,
        output addr_t       ram_rd_addr_o,
        output addr_t       vram_wr_addr_o,
        output addr_t       ram_wr_addr_o,
        output cell_e       vram_wr_data_o,
        output cell_e       ram_wr_data_o,
        output logic        vram_wr_en_o,
        output logic        ram_wr_en_o,
        output logic        done_o
    );

    probe_t    probe;
    logic      probe_valid;
    move_cmd_t cmd;
    logic      cmd_valid;
    logic      write_done;

    initial begin
        assert (COLUMNS * ROWS <= 2 ** ADDR_WIDTH)
            else $fatal(1, "Grid %0d x %0d needs more than %0d address bits",
                        COLUMNS, ROWS, ADDR_WIDTH);
    end

    sand_scanner #(
        .COLUMNS (COLUMNS),
        .ROWS    (ROWS)
    ) u_scanner (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .ready_i        (ready_i),
        .vram_rd_data_i (vram_rd_data_i),
        .ram_rd_data_i  (ram_rd_data_i),
        .write_done_i   (write_done),
        .vram_rd_addr_o (vram_rd_addr_o),
        .ram_rd_addr_o  (ram_rd_addr_o),
        .probe_o        (probe),
        .probe_valid_o  (probe_valid),
        .done_o         (done_o)
    );

    fall_chooser u_chooser (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .probe_i       (probe),
        .probe_valid_i (probe_valid),
        .cmd_o         (cmd),
        .cmd_valid_o   (cmd_valid)
    );

    frame_writer #(
        .COLUMNS (COLUMNS)
    ) u_writer (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .cmd_i          (cmd),
        .cmd_valid_i    (cmd_valid),
        .vram_wr_addr_o (vram_wr_addr_o),
        .vram_wr_data_o (vram_wr_data_o),
        .vram_wr_en_o   (vram_wr_en_o),
        .ram_wr_addr_o  (ram_wr_addr_o),
        .ram_wr_data_o  (ram_wr_data_o),
        .ram_wr_en_o    (ram_wr_en_o),
        .write_done_o   (write_done)
    );

endmodule

`default_nettype wire

// ==== design/frame_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_writer
    import sand_pkg::*;
    #(
        parameter int COLUMNS = 640
    )(
        input  wire             clk_i,
        input  wire             reset_i,
        input  wire move_cmd_t  cmd_i,
        input  wire             cmd_valid_i,
        output addr_t           vram_wr_addr_o,
        output cell_e           vram_wr_data_o,
        output logic            vram_wr_en_o,
        output addr_t           ram_wr_addr_o,
        output cell_e           ram_wr_data_o,
        output logic            ram_wr_en_o,
        output logic            write_done_o
    );

    localparam addr_t ROW_STEP = addr_t'(COLUMNS);

    addr_t target;

    always_comb begin
        case (cmd_i.move)
            MOVE_DOWN:       target = cmd_i.base + ROW_STEP;
            MOVE_DOWN_LEFT:  target = cmd_i.base + ROW_STEP - addr_t'(1);
            MOVE_DOWN_RIGHT: target = cmd_i.base + ROW_STEP + addr_t'(1);
            default:         target = cmd_i.base;
        endcase
    end

    always_ff @(posedge clk_i, posedge reset_i) begin
        if (reset_i) begin
            vram_wr_en_o <= 1'b0;
            ram_wr_en_o <= 1'b0;
            write_done_o <= 1'b0;
        end else begin
            // Source in vram is only cleared when the grain leaves it
            vram_wr_en_o <= cmd_valid_i && (cmd_i.move != MOVE_STAY);
            ram_wr_en_o <= cmd_valid_i;
            write_done_o <= cmd_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd_valid_i) begin
            vram_wr_addr_o <= cmd_i.base;
            vram_wr_data_o <= CELL_EMPTY;
            ram_wr_addr_o <= target;
            ram_wr_data_o <= cmd_i.kind;
        end
    end

    // A move is one paired write to two different cells
    a_move_pairs_writes: assert property (@(posedge clk_i) disable iff (reset_i)
        vram_wr_en_o |-> (ram_wr_en_o && ram_wr_addr_o != vram_wr_addr_o)
            ##1 !vram_wr_en_o);

endmodule

`default_nettype wire

// ==== design/fall_chooser.sv ====
`timescale 1ns/1ps
`default_nettype none

module fall_chooser
    import sand_pkg::*;
    (
        input  wire          clk_i,
        input  wire          reset_i,
        input  wire probe_t  probe_i,
        input  wire          probe_valid_i,
        output move_cmd_t    cmd_o,
        output logic         cmd_valid_o
    );

    lfsr_t lfsr_q;
    rand_t rand_q;
    move_e move;
    logic  free_down, free_left, free_right;

    assign free_down  = !probe_i.occupied[OCC_DOWN];
    assign free_left  = !probe_i.occupied[OCC_LEFT];
    assign free_right = !probe_i.occupied[OCC_RIGHT];

    // Free-running, so the draw depends on when the grain arrives
    always_ff @(posedge clk_i, posedge reset_i) begin
        if (reset_i) begin
            lfsr_q <= LFSR_SEED;
            rand_q <= '0;
            cmd_valid_o <= 1'b0;
        end else begin
            lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
            if (lfsr_q[7]) begin
                rand_q <= rand_q + 1'b1;
            end
            cmd_valid_o <= probe_valid_i;
        end
    end

    always_comb begin
        move = MOVE_STAY;
        if (probe_i.kind == CELL_SAND && !probe_i.on_bottom) begin
            if (free_down) begin
                // Mostly straight down, 1 in 8 each way
                if (rand_q == 3'd6 && free_left) begin
                    move = MOVE_DOWN_LEFT;
                end else if (rand_q == 3'd7 && free_right) begin
                    move = MOVE_DOWN_RIGHT;
                end else begin
                    move = MOVE_DOWN;
                end
            end else if (free_left && free_right) begin
                move = rand_q[0] ? MOVE_DOWN_RIGHT : MOVE_DOWN_LEFT;
            end else if (free_left) begin
                move = MOVE_DOWN_LEFT;
            end else if (free_right) begin
                move = MOVE_DOWN_RIGHT;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (probe_valid_i) begin
            cmd_o.base <= probe_i.base;
            cmd_o.kind <= probe_i.kind;
            cmd_o.move <= move;
        end
    end

    a_target_free: assert property (@(posedge clk_i) disable iff (reset_i)
        probe_valid_i |=> cmd_valid_o
            && !(cmd_o.move == MOVE_DOWN && $past(probe_i.occupied[OCC_DOWN]))
            && !(cmd_o.move == MOVE_DOWN_LEFT && $past(probe_i.occupied[OCC_LEFT]))
            && !(cmd_o.move == MOVE_DOWN_RIGHT && $past(probe_i.occupied[OCC_RIGHT])));

endmodule

`default_nettype wire

// ==== design/sand_scanner.sv ====
`timescale 1ns/1ps
`default_nettype none

module sand_scanner
    import sand_pkg::*;
    #(
        parameter int COLUMNS = 640,
        parameter int ROWS = 480
    )(
        input  wire         clk_i,
        input  wire         reset_i,
        input  wire         ready_i,
        input  wire cell_e  vram_rd_data_i,
        input  wire cell_e  ram_rd_data_i,
        input  wire         write_done_i,
        output addr_t       vram_rd_addr_o,
        output addr_t       ram_rd_addr_o,
        output probe_t      probe_o,
        output logic        probe_valid_o,
        output logic        done_o
    );

    localparam addr_t ROW_STEP  = addr_t'(COLUMNS);
    localparam addr_t LAST_ROW  = addr_t'((ROWS - 1) * COLUMNS);
    localparam addr_t LAST_CELL = addr_t'(COLUMNS * ROWS - 1);
    localparam addr_t LAST_COL  = addr_t'(COLUMNS - 1);

    typedef enum logic [2:0] {
        SCAN_IDLE,
        SCAN_CELL,
        SCAN_DOWN,
        SCAN_DOWN_LEFT,
        SCAN_DOWN_RIGHT,
        SCAN_WAIT,
        SCAN_NEXT
    } scan_state_e;

    scan_state_e state_q, state_d;
    addr_t base_q, base_d;
    addr_t col_q, col_d;
    addr_t base_inc, col_inc;
    addr_t rd_addr;
    cell_e kind_q;
    logic  occ_down_q, occ_left_q;
    logic  done_q, done_d;
    logic  nb_occ;
    logic  on_bottom, left_edge, right_edge, last_cell;

    assign base_inc   = base_q + addr_t'(1);
    assign col_inc    = (col_q == LAST_COL) ? '0 : col_q + addr_t'(1);
    assign on_bottom  = (base_q >= LAST_ROW);
    assign left_edge  = (col_q == '0);
    assign right_edge = (col_q == LAST_COL);
    assign last_cell  = (base_q == LAST_CELL);

    // A neighbor is taken if either frame holds something there
    assign nb_occ = (vram_rd_data_i != CELL_EMPTY) || (ram_rd_data_i != CELL_EMPTY);

    always_ff @(posedge clk_i, posedge reset_i) begin
        if (reset_i) begin
            state_q <= SCAN_IDLE;
            base_q <= '0;
            col_q <= '0;
            done_q <= 1'b0;
        end else begin
            state_q <= state_d;
            base_q <= base_d;
            col_q <= col_d;
            done_q <= done_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == SCAN_CELL) begin
            kind_q <= vram_rd_data_i;
        end
        if (state_q == SCAN_DOWN) begin
            occ_down_q <= nb_occ;
        end
        if (state_q == SCAN_DOWN_LEFT) begin
            occ_left_q <= nb_occ | left_edge;
        end
    end

    always_comb begin
        state_d = state_q;
        base_d = base_q;
        col_d = col_q;
        done_d = 1'b0;
        rd_addr = base_q;
        probe_valid_o = 1'b0;
        probe_o.base = base_q;
        probe_o.kind = kind_q;
        probe_o.on_bottom = on_bottom;
        probe_o.occupied = 3'b111;

        case (state_q)
            SCAN_IDLE: begin
                rd_addr = '0;
                if (ready_i) begin
                    base_d = '0;
                    col_d = '0;
                    state_d = SCAN_CELL;
                end
            end
            SCAN_CELL: begin
                if (vram_rd_data_i == CELL_EMPTY) begin
                    if (last_cell) begin
                        done_d = 1'b1;
                        state_d = SCAN_IDLE;
                    end else begin
                        base_d = base_inc;
                        col_d = col_inc;
                        rd_addr = base_inc;
                    end
                end else if (vram_rd_data_i == CELL_SAND && !on_bottom) begin
                    rd_addr = base_q + ROW_STEP;
                    state_d = SCAN_DOWN;
                end else begin
                    // Obstacle or grain on the floor is copied in place
                    probe_o.kind = vram_rd_data_i;
                    probe_valid_o = 1'b1;
                    state_d = SCAN_WAIT;
                end
            end
            SCAN_DOWN: begin
                rd_addr = base_q + ROW_STEP - addr_t'(1);
                state_d = SCAN_DOWN_LEFT;
            end
            SCAN_DOWN_LEFT: begin
                rd_addr = base_q + ROW_STEP + addr_t'(1);
                state_d = SCAN_DOWN_RIGHT;
            end
            SCAN_DOWN_RIGHT: begin
                probe_o.occupied[OCC_DOWN] = occ_down_q;
                probe_o.occupied[OCC_LEFT] = occ_left_q;
                probe_o.occupied[OCC_RIGHT] = nb_occ | right_edge;
                probe_valid_o = 1'b1;
                state_d = SCAN_WAIT;
            end
            SCAN_WAIT: begin
                if (write_done_i) begin
                    state_d = SCAN_NEXT;
                end
            end
            SCAN_NEXT: begin
                if (last_cell) begin
                    done_d = 1'b1;
                    state_d = SCAN_IDLE;
                end else begin
                    base_d = base_inc;
                    col_d = col_inc;
                    rd_addr = base_inc;
                    state_d = SCAN_CELL;
                end
            end
            default: state_d = SCAN_IDLE;
        endcase
    end

    assign vram_rd_addr_o = rd_addr;
    assign ram_rd_addr_o = rd_addr;
    assign done_o = done_q;

    // Writer answers each probe two cycles later in the wait state
    a_write_done_in_wait: assert property (@(posedge clk_i) disable iff (reset_i)
        probe_valid_o |-> ##2 (write_done_i && state_q == SCAN_WAIT));

endmodule

`default_nettype wire

// ==== common/sand_pkg.sv ====
`default_nettype none

package sand_pkg;

    // Enough for a 640 x 480 grid
    localparam int ADDR_WIDTH = 19;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [7:0] lfsr_t;
    typedef logic [2:0] rand_t;

    localparam lfsr_t LFSR_SEED = 8'd1;

    typedef enum logic [1:0] {
        CELL_EMPTY = 2'b00,
        CELL_SAND  = 2'b01,
        // Water and smoke only sit in place here
        CELL_WATER = 2'b10,
        CELL_SMOKE = 2'b11
    } cell_e;

    typedef enum logic [1:0] {
        MOVE_STAY       = 2'b00,
        MOVE_DOWN       = 2'b01,
        MOVE_DOWN_LEFT  = 2'b10,
        MOVE_DOWN_RIGHT = 2'b11
    } move_e;

    // Bit positions in probe_t.occupied
    localparam int OCC_DOWN  = 0;
    localparam int OCC_LEFT  = 1;
    localparam int OCC_RIGHT = 2;

    typedef struct packed {
        addr_t      base;
        cell_e      kind;
        logic       on_bottom;
        logic [2:0] occupied;
    } probe_t;

    typedef struct packed {
        addr_t base;
        cell_e kind;
        move_e move;
    } move_cmd_t;

endpackage

`default_nettype wire
